// File: hw/rv_config.svh
`ifndef RV_CONFIG_SVH
`define RV_CONFIG_SVH

`define RV_XLEN     32
`define RV_NREGS    32
`define RV_RESET_PC 32'h0000_0000

`endif

// File: hw/isa_pkg.sv
`include "rv_config.svh"

package isa_pkg;

        typedef logic [`RV_XLEN-1:0] word_t;
        typedef logic [$clog2(`RV_NREGS)-1:0] reg_idx_t;
        typedef logic [6:0] opcode_t;

        typedef enum logic [2:0] {
                R_TYPE, I_TYPE, S_TYPE, B_TYPE, U_TYPE, J_TYPE, HALT_TYPE
        } encoding_t;

        localparam opcode_t OP_LOAD   = 7'b0000011;
        localparam opcode_t OP_IMM    = 7'b0010011;
        localparam opcode_t OP_AUIPC  = 7'b0010111;
        localparam opcode_t OP_STORE  = 7'b0100011;
        localparam opcode_t OP_REG    = 7'b0110011;
        localparam opcode_t OP_LUI    = 7'b0110111;
        localparam opcode_t OP_BRANCH = 7'b1100011;
        localparam opcode_t OP_JALR   = 7'b1100111;
        localparam opcode_t OP_JAL    = 7'b1101111;
        localparam opcode_t OP_HALT   = 7'b1111111;

        // funct7 rs2 rs1 funct3 rd opcode
        localparam word_t INSTR_LUI   = 32'b???????_?????_?????_???_?????_0110111;
        localparam word_t INSTR_AUIPC = 32'b???????_?????_?????_???_?????_0010111;
        localparam word_t INSTR_JAL   = 32'b???????_?????_?????_???_?????_1101111;
        localparam word_t INSTR_JALR  = 32'b???????_?????_?????_000_?????_1100111;
        localparam word_t INSTR_BEQ   = 32'b???????_?????_?????_000_?????_1100011;
        localparam word_t INSTR_BNE   = 32'b???????_?????_?????_001_?????_1100011;
        localparam word_t INSTR_BLT   = 32'b???????_?????_?????_100_?????_1100011;
        localparam word_t INSTR_BGE   = 32'b???????_?????_?????_101_?????_1100011;
        localparam word_t INSTR_BLTU  = 32'b???????_?????_?????_110_?????_1100011;
        localparam word_t INSTR_BGEU  = 32'b???????_?????_?????_111_?????_1100011;
        localparam word_t INSTR_LB    = 32'b???????_?????_?????_000_?????_0000011;
        localparam word_t INSTR_LH    = 32'b???????_?????_?????_001_?????_0000011;
        localparam word_t INSTR_LW    = 32'b???????_?????_?????_010_?????_0000011;
        localparam word_t INSTR_LBU   = 32'b???????_?????_?????_100_?????_0000011;
        localparam word_t INSTR_LHU   = 32'b???????_?????_?????_101_?????_0000011;
        localparam word_t INSTR_SB    = 32'b???????_?????_?????_000_?????_0100011;
        localparam word_t INSTR_SH    = 32'b???????_?????_?????_001_?????_0100011;
        localparam word_t INSTR_SW    = 32'b???????_?????_?????_010_?????_0100011;
        localparam word_t INSTR_ADDI  = 32'b???????_?????_?????_000_?????_0010011;
        localparam word_t INSTR_SLTI  = 32'b???????_?????_?????_010_?????_0010011;
        localparam word_t INSTR_SLTIU = 32'b???????_?????_?????_011_?????_0010011;
        localparam word_t INSTR_XORI  = 32'b???????_?????_?????_100_?????_0010011;
        localparam word_t INSTR_ORI   = 32'b???????_?????_?????_110_?????_0010011;
        localparam word_t INSTR_ANDI  = 32'b???????_?????_?????_111_?????_0010011;
        localparam word_t INSTR_SLLI  = 32'b0000000_?????_?????_001_?????_0010011;
        localparam word_t INSTR_SRLI  = 32'b0000000_?????_?????_101_?????_0010011;
        localparam word_t INSTR_SRAI  = 32'b0100000_?????_?????_101_?????_0010011;
        localparam word_t INSTR_ADD   = 32'b0000000_?????_?????_000_?????_0110011;
        localparam word_t INSTR_SUB   = 32'b0100000_?????_?????_000_?????_0110011;
        localparam word_t INSTR_SLL   = 32'b0000000_?????_?????_001_?????_0110011;
        localparam word_t INSTR_SLT   = 32'b0000000_?????_?????_010_?????_0110011;
        localparam word_t INSTR_SLTU  = 32'b0000000_?????_?????_011_?????_0110011;
        localparam word_t INSTR_XOR   = 32'b0000000_?????_?????_100_?????_0110011;
        localparam word_t INSTR_SRL   = 32'b0000000_?????_?????_101_?????_0110011;
        localparam word_t INSTR_SRA   = 32'b0100000_?????_?????_101_?????_0110011;
        localparam word_t INSTR_OR    = 32'b0000000_?????_?????_110_?????_0110011;
        localparam word_t INSTR_AND   = 32'b0000000_?????_?????_111_?????_0110011;
        localparam word_t INSTR_HALT  = 32'b???????_?????_?????_???_?????_1111111;

endpackage

// File: hw/ctrl_pkg.sv
package ctrl_pkg;

        typedef enum logic [3:0] {
                ALU_ADD,
                ALU_SUB,
                ALU_AND,
                ALU_OR,
                ALU_XOR,
                ALU_SHIFT_LEFT,
                ALU_SHIFT_RIGHT,
                ALU_SHIFT_RIGHT_AR,
                ALU_LESS_THAN_SIGNED,
                ALU_LESS_THAN_UNSIGNED,
                ALU_EQUAL
        } alu_op_t;

        typedef enum logic [2:0] {
                MEM_NONE,
                MEM_BYTE,
                MEM_HALF_WORD,
                MEM_FULL_WORD,
                MEM_BYTE_U,
                MEM_HALF_WORD_U
        } mem_size_t;

        typedef enum logic [2:0] {
                FETCH,
                FETCH_RELEASE,
                EXECUTE,
                MEM,
                MEM_RELEASE,
                WRITE_BACK,
                HALTED // left only by reset
        } core_state_t;

endpackage

// File: hw/control.sv
`timescale 1ns/1ps

module control (
        input  isa_pkg::word_t      instruction,
        output isa_pkg::encoding_t  encoding,
        output ctrl_pkg::alu_op_t   alu_op,
        output logic                alu_src,
        output logic                alu_pc,
        output logic                alu_bypass,
        output logic                alu_inv_res,
        output logic                alu_jump,
        output logic                is_branch,
        output logic                wb_pc,
        output logic                reg_write,
        output ctrl_pkg::mem_size_t mem_read,
        output ctrl_pkg::mem_size_t mem_write,
        output logic                halt
);

        logic known; // word matched one of the patterns

        always_comb begin
                case (instruction[6:0])
                        isa_pkg::OP_REG: encoding = isa_pkg::R_TYPE;
                        isa_pkg::OP_IMM, isa_pkg::OP_JALR, isa_pkg::OP_LOAD:
                                encoding = isa_pkg::I_TYPE;
                        isa_pkg::OP_STORE: encoding = isa_pkg::S_TYPE;
                        isa_pkg::OP_BRANCH: encoding = isa_pkg::B_TYPE;
                        isa_pkg::OP_LUI, isa_pkg::OP_AUIPC: encoding = isa_pkg::U_TYPE;
                        isa_pkg::OP_JAL: encoding = isa_pkg::J_TYPE;
                        isa_pkg::OP_HALT: encoding = isa_pkg::HALT_TYPE;
                        default: encoding = isa_pkg::R_TYPE; // treated as nop
                endcase
        end

        always_comb begin
                alu_op = ctrl_pkg::ALU_ADD;
                alu_src = 1'b0;
                alu_pc = 1'b0;
                alu_bypass = 1'b0;
                alu_inv_res = 1'b0;
                alu_jump = 1'b0;
                is_branch = 1'b0;
                wb_pc = 1'b0;
                reg_write = 1'b0;
                mem_read = ctrl_pkg::MEM_NONE;
                mem_write = ctrl_pkg::MEM_NONE;
                halt = 1'b0;
                known = 1'b1;

                casez (instruction)
                        isa_pkg::INSTR_LUI: begin
                                alu_src = 1'b1;
                                alu_bypass = 1'b1; // imm straight to rd
                                reg_write = 1'b1;
                        end
                        isa_pkg::INSTR_AUIPC: begin
                                alu_src = 1'b1;
                                alu_pc = 1'b1;
                                reg_write = 1'b1;
                        end
                        isa_pkg::INSTR_JAL, isa_pkg::INSTR_JALR: begin
                                alu_src = 1'b1;
                                alu_pc = instruction[3]; // set for jal only
                                alu_jump = 1'b1;
                                wb_pc = 1'b1;
                                reg_write = 1'b1;
                        end
                        isa_pkg::INSTR_BEQ, isa_pkg::INSTR_BNE:
                                alu_op = ctrl_pkg::ALU_EQUAL;
                        isa_pkg::INSTR_BLT, isa_pkg::INSTR_BGE:
                                alu_op = ctrl_pkg::ALU_LESS_THAN_SIGNED;
                        isa_pkg::INSTR_BLTU, isa_pkg::INSTR_BGEU:
                                alu_op = ctrl_pkg::ALU_LESS_THAN_UNSIGNED;
                        isa_pkg::INSTR_LB: mem_read = ctrl_pkg::MEM_BYTE;
                        isa_pkg::INSTR_LH: mem_read = ctrl_pkg::MEM_HALF_WORD;
                        isa_pkg::INSTR_LW: mem_read = ctrl_pkg::MEM_FULL_WORD;
                        isa_pkg::INSTR_LBU: mem_read = ctrl_pkg::MEM_BYTE_U;
                        isa_pkg::INSTR_LHU: mem_read = ctrl_pkg::MEM_HALF_WORD_U;
                        isa_pkg::INSTR_SB: mem_write = ctrl_pkg::MEM_BYTE;
                        isa_pkg::INSTR_SH: mem_write = ctrl_pkg::MEM_HALF_WORD;
                        isa_pkg::INSTR_SW: mem_write = ctrl_pkg::MEM_FULL_WORD;
                        isa_pkg::INSTR_ADDI, isa_pkg::INSTR_ADD:
                                alu_op = ctrl_pkg::ALU_ADD;
                        isa_pkg::INSTR_SUB: alu_op = ctrl_pkg::ALU_SUB;
                        isa_pkg::INSTR_SLTI, isa_pkg::INSTR_SLT:
                                alu_op = ctrl_pkg::ALU_LESS_THAN_SIGNED;
                        isa_pkg::INSTR_SLTIU, isa_pkg::INSTR_SLTU:
                                alu_op = ctrl_pkg::ALU_LESS_THAN_UNSIGNED;
                        isa_pkg::INSTR_XORI, isa_pkg::INSTR_XOR:
                                alu_op = ctrl_pkg::ALU_XOR;
                        isa_pkg::INSTR_ORI, isa_pkg::INSTR_OR:
                                alu_op = ctrl_pkg::ALU_OR;
                        isa_pkg::INSTR_ANDI, isa_pkg::INSTR_AND:
                                alu_op = ctrl_pkg::ALU_AND;
                        isa_pkg::INSTR_SLLI, isa_pkg::INSTR_SLL:
                                alu_op = ctrl_pkg::ALU_SHIFT_LEFT;
                        isa_pkg::INSTR_SRLI, isa_pkg::INSTR_SRL:
                                alu_op = ctrl_pkg::ALU_SHIFT_RIGHT;
                        isa_pkg::INSTR_SRAI, isa_pkg::INSTR_SRA:
                                alu_op = ctrl_pkg::ALU_SHIFT_RIGHT_AR;
                        isa_pkg::INSTR_HALT: halt = 1'b1;
                        default: known = 1'b0;
                endcase

                if (!known) begin
                        alu_op = ctrl_pkg::ALU_AND; // andi x0, harmless
                        alu_src = 1'b1;
                end
                if (encoding == isa_pkg::B_TYPE) begin
                        is_branch = known;
                        alu_inv_res = known & instruction[12]; // bne, bge, bgeu
                end
                if (mem_read != ctrl_pkg::MEM_NONE || mem_write != ctrl_pkg::MEM_NONE) begin
                        alu_src = 1'b1; // address is rs1 plus offset
                end
                if (mem_read != ctrl_pkg::MEM_NONE) begin
                        reg_write = 1'b1;
                end
                if (known && (instruction[6:0] == isa_pkg::OP_REG
                              || instruction[6:0] == isa_pkg::OP_IMM)) begin
                        alu_src = ~instruction[5]; // op-imm has bit 5 clear
                        reg_write = 1'b1;
                end

                assert (mem_read == ctrl_pkg::MEM_NONE || mem_write == ctrl_pkg::MEM_NONE)
                else $error("load and store decoded from one word");
        end

endmodule

// File: hw/alu.sv
`timescale 1ns/1ps
`include "rv_config.svh"

module alu (
        input  ctrl_pkg::alu_op_t alu_op,
        input  isa_pkg::word_t    operand_a,
        input  isa_pkg::word_t    operand_b,
        input  logic              inv_res,
        output isa_pkg::word_t    result
);

        logic [$clog2(`RV_XLEN)-1:0] shamt;
        logic lt_s;
        logic lt_u;
        isa_pkg::word_t raw;

        assign shamt = operand_b[$clog2(`RV_XLEN)-1:0];
        assign lt_s = $signed(operand_a) < $signed(operand_b);
        assign lt_u = operand_a < operand_b;

        always_comb begin
                case (alu_op)
                        ctrl_pkg::ALU_ADD: raw = operand_a + operand_b;
                        ctrl_pkg::ALU_SUB: raw = operand_a - operand_b;
                        ctrl_pkg::ALU_AND: raw = operand_a & operand_b;
                        ctrl_pkg::ALU_OR: raw = operand_a | operand_b;
                        ctrl_pkg::ALU_XOR: raw = operand_a ^ operand_b;
                        ctrl_pkg::ALU_SHIFT_LEFT: raw = operand_a << shamt;
                        ctrl_pkg::ALU_SHIFT_RIGHT: raw = operand_a >> shamt;
                        ctrl_pkg::ALU_SHIFT_RIGHT_AR: raw = $signed(operand_a) >>> shamt;
                        ctrl_pkg::ALU_LESS_THAN_SIGNED: raw = isa_pkg::word_t'(lt_s);
                        ctrl_pkg::ALU_LESS_THAN_UNSIGNED: raw = isa_pkg::word_t'(lt_u);
                        ctrl_pkg::ALU_EQUAL: raw = isa_pkg::word_t'(operand_a == operand_b);
                        default: raw = '0;
                endcase
        end

        // inversion turns beq/blt/bltu into bne/bge/bgeu
        assign result = {raw[`RV_XLEN-1:1], raw[0] ^ inv_res};

endmodule

// File: hw/reg_file.sv
`timescale 1ns/1ps
`include "rv_config.svh"

module reg_file (
        input  logic              clk,
        input  logic              arst_n,
        input  isa_pkg::reg_idx_t rs1,
        input  isa_pkg::reg_idx_t rs2,
        input  isa_pkg::reg_idx_t rd,
        input  logic              we,
        input  isa_pkg::word_t    wdata,
        output isa_pkg::word_t    rdata1,
        output isa_pkg::word_t    rdata2
);

        isa_pkg::word_t regs [`RV_NREGS];

        always_ff @(posedge clk or negedge arst_n) begin
                if (!arst_n) begin
                        regs <= '{default: '0};
                end else if (we && rd != '0) begin // x0 is never written
                        regs[rd] <= wdata;
                end
        end

        assign rdata1 = regs[rs1];
        assign rdata2 = regs[rs2];

        // x0 keeps its reset value for the whole run
        a_x0_zero: assert property (@(posedge clk) disable iff (!arst_n)
                rs1 == '0 |-> rdata1 == '0);

endmodule

// File: hw/core.sv
`timescale 1ns/1ps
`include "rv_config.svh"

module core (
        input  logic                clk,
        input  logic                arst_n,
        output logic                mem_req,
        output logic                mem_we,
        output isa_pkg::word_t      mem_addr,
        output isa_pkg::word_t      mem_wdata,
        output ctrl_pkg::mem_size_t mem_size,
        input  logic                mem_ack,
        input  isa_pkg::word_t      mem_rdata,
        output logic                halted
);

        ctrl_pkg::core_state_t state;
        isa_pkg::word_t pc, ir, load_data;
        isa_pkg::word_t imm, rdata1, rdata2, operand_a, operand_b, alu_out, alu_result;
        isa_pkg::word_t pc_plus4, next_pc, load_word, load_ext, wb_data;
        isa_pkg::encoding_t encoding;
        ctrl_pkg::alu_op_t alu_op;
        ctrl_pkg::mem_size_t mem_read, mem_write;
        logic alu_src, alu_pc, alu_bypass, alu_inv_res, alu_jump, is_branch, wb_pc;
        logic reg_write, halt, mem_access;

        control u_control (
                .instruction (ir),
                .*
        );

        alu u_alu (
                .alu_op    (alu_op),
                .operand_a (operand_a),
                .operand_b (operand_b),
                .inv_res   (alu_inv_res),
                .result    (alu_out)
        );

        reg_file u_reg_file (
                .clk    (clk),
                .arst_n (arst_n),
                .rs1    (ir[19:15]),
                .rs2    (ir[24:20]),
                .rd     (ir[11:7]),
                .we     (state == ctrl_pkg::WRITE_BACK && reg_write),
                .wdata  (wb_data),
                .rdata1 (rdata1),
                .rdata2 (rdata2)
        );

        always_comb begin
                case (encoding)
                        isa_pkg::I_TYPE: imm = {{20{ir[31]}}, ir[31:20]};
                        isa_pkg::S_TYPE: imm = {{20{ir[31]}}, ir[31:25], ir[11:7]};
                        isa_pkg::B_TYPE: imm = {{20{ir[31]}}, ir[7], ir[30:25], ir[11:8], 1'b0};
                        isa_pkg::U_TYPE: imm = {ir[31:12], 12'b0};
                        isa_pkg::J_TYPE: imm = {{12{ir[31]}}, ir[19:12], ir[20], ir[30:21], 1'b0};
                        default: imm = '0;
                endcase
        end

        assign operand_a = alu_pc ? pc : rdata1;
        assign operand_b = alu_src ? imm : rdata2;
        assign alu_result = alu_bypass ? imm : alu_out;
        assign pc_plus4 = pc + 4;
        assign next_pc = (is_branch && alu_result[0]) ? pc + imm
                       : alu_jump ? {alu_result[`RV_XLEN-1:1], 1'b0} : pc_plus4;

        // memory returns the aligned word, pick the lane here
        assign load_word = load_data >> {alu_result[1:0], 3'b000};

        always_comb begin
                case (mem_read)
                        ctrl_pkg::MEM_BYTE: load_ext = {{24{load_word[7]}}, load_word[7:0]};
                        ctrl_pkg::MEM_HALF_WORD: load_ext = {{16{load_word[15]}}, load_word[15:0]};
                        ctrl_pkg::MEM_BYTE_U: load_ext = {24'b0, load_word[7:0]};
                        ctrl_pkg::MEM_HALF_WORD_U: load_ext = {16'b0, load_word[15:0]};
                        default: load_ext = load_word;
                endcase
        end

        assign wb_data = wb_pc ? pc_plus4
                       : (mem_read != ctrl_pkg::MEM_NONE) ? load_ext : alu_result;

        assign mem_access = (mem_read != ctrl_pkg::MEM_NONE) || (mem_write != ctrl_pkg::MEM_NONE);
        assign mem_req = (state == ctrl_pkg::FETCH) || (state == ctrl_pkg::MEM);
        assign mem_we = (state == ctrl_pkg::MEM) && (mem_write != ctrl_pkg::MEM_NONE);
        assign mem_addr = (state == ctrl_pkg::MEM) ? alu_result : pc;
        assign mem_wdata = rdata2; // low bits, memory masks by size
        assign mem_size = (state != ctrl_pkg::MEM) ? ctrl_pkg::MEM_FULL_WORD
                        : mem_we ? mem_write : mem_read;
        assign halted = (state == ctrl_pkg::HALTED);

        always_ff @(posedge clk or negedge arst_n) begin
                if (!arst_n) begin
                        state <= ctrl_pkg::FETCH;
                        pc <= `RV_RESET_PC;
                end else begin
                        case (state)
                                ctrl_pkg::FETCH:
                                        if (mem_ack) state <= ctrl_pkg::FETCH_RELEASE;
                                ctrl_pkg::FETCH_RELEASE:
                                        if (!mem_ack) state <= ctrl_pkg::EXECUTE;
                                ctrl_pkg::EXECUTE: begin
                                        if (halt) state <= ctrl_pkg::HALTED;
                                        else if (mem_access) state <= ctrl_pkg::MEM;
                                        else state <= ctrl_pkg::WRITE_BACK;
                                end
                                ctrl_pkg::MEM:
                                        if (mem_ack) state <= ctrl_pkg::MEM_RELEASE;
                                ctrl_pkg::MEM_RELEASE:
                                        if (!mem_ack) state <= ctrl_pkg::WRITE_BACK;
                                ctrl_pkg::WRITE_BACK: begin
                                        pc <= next_pc;
                                        state <= ctrl_pkg::FETCH;
                                end
                                ctrl_pkg::HALTED: state <= ctrl_pkg::HALTED;
                                default: state <= ctrl_pkg::FETCH;
                        endcase
                end
        end

        always_ff @(posedge clk) begin
                if (state == ctrl_pkg::FETCH && mem_ack) ir <= mem_rdata;
                if (state == ctrl_pkg::MEM && mem_ack) load_data <= mem_rdata;
        end

        // four-phase rules seen from the memory side
        a_req_drop: assert property (@(posedge clk) disable iff (!arst_n)
                $fell(mem_req) |-> mem_ack);
        a_req_stable: assert property (@(posedge clk) disable iff (!arst_n)
                mem_req && !mem_ack |=> mem_req && $stable(mem_addr)
                                        && $stable(mem_we) && $stable(mem_size));

endmodule

// File: test/clk_gen.sv
`timescale 1ns/1ps

module clk_gen (
        output logic clk,
        output logic arst_n
);

        initial begin
                clk = 1'b0;
                forever #4 clk = ~clk; // 8 ns period
        end

        initial begin
                arst_n = 1'b0;
                repeat (3) @(posedge clk);
                @(negedge clk) arst_n = 1'b1;
        end

endmodule

// File: test/tb_core.sv
`timescale 1ns/1ps

module tb_core;

        logic clk, arst_n;
        logic mem_req, mem_we, halted;
        logic [31:0] mem_addr, mem_wdata;
        ctrl_pkg::mem_size_t mem_size;
        logic mem_ack = 1'b0;
        logic [31:0] mem_rdata = '0;

        logic [31:0] mem [0:1023];
        logic [31:0] exp_addr [$];
        logic [31:0] exp_data [$];
        int exp_size [$];
        logic [127:0] exp_name [$];
        int n_expected = 0;
        int store_count = 0;
        int store_fail = 0;
        int store_pass = 0;
        bit loaded = 1'b0;

        clk_gen u_clk_gen (.clk(clk), .arst_n(arst_n));

        core dut (.*);

        function automatic logic [15:0] lfsr_next(input logic [15:0] s);
                return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
        endfunction

        function automatic logic [31:0] size_mask(input int sz);
                return (sz == 1) ? 32'h0000_00ff : (sz == 2) ? 32'h0000_ffff : 32'hffff_ffff;
        endfunction

        // compares one store against the next expected event
        task automatic check_store(input logic [31:0] a, input int sz, input logic [31:0] d);
                logic [31:0] ea, ed;
                int es;
                logic [127:0] nm;
                store_count++;
                if (exp_addr.size() == 0) begin
                        $display("unexpected store to %h with data %h", a, d);
                        store_fail++;
                        return;
                end
                ea = exp_addr.pop_front();
                ed = exp_data.pop_front();
                es = exp_size.pop_front();
                nm = exp_name.pop_front();
                if (a != ea || sz != es || (d & size_mask(sz)) != ed) begin
                        $display("[ERROR] %0s: expected a=%h s=%0d d=%h, actual a=%h s=%0d d=%h",
                                 nm, ea, es, ed, a, sz, d & size_mask(sz));
                        store_fail++;
                end else begin
                        $display("ok %0s", nm);
                        store_pass++;
                end
        endtask

        // trace loading, then the memory side of the handshake
        initial begin
                int fd, r, sz, wait_left, off, nb;
                logic [7:0] kind;
                logic [31:0] a, w, lane;
                logic [127:0] nm;
                logic [15:0] lfsr;
                bit busy;
                string line;
                for (int i = 0; i < 1024; i++) mem[i] = 32'h5a5a_0000 ^ (i * 4);
                fd = $fopen("test/core_trace.txt", "r");
                if (fd == 0) $display("cannot open test/core_trace.txt");
                while (fd != 0 && !$feof(fd)) begin
                        r = $fscanf(fd, " %c", kind);
                        if (r != 1) break;
                        if (kind == "#") begin
                                r = $fgets(line, fd);
                        end else if (kind == "P" || kind == "D") begin
                                r = $fscanf(fd, "%h %h", a, w);
                                mem[a[11:2]] = w;
                        end else if (kind == "S") begin
                                r = $fscanf(fd, "%h %d %h %s", a, sz, w, nm);
                                exp_addr.push_back(a);
                                exp_size.push_back(sz);
                                exp_data.push_back(w);
                                exp_name.push_back(nm);
                                n_expected++;
                        end
                end
                if (fd != 0) $fclose(fd);
                loaded = (fd != 0);
                lfsr = 16'd88;
                busy = 1'b0;
                wait_left = 0;
                forever begin
                        @(posedge clk);
                        if (mem_req && !mem_ack) begin
                                if (!busy) begin
                                        wait_left = lfsr[0]; // two bits per delay
                                        lfsr = lfsr_next(lfsr);
                                        wait_left = wait_left | (lfsr[0] << 1);
                                        lfsr = lfsr_next(lfsr);
                                        busy = 1'b1;
                                end else if (wait_left > 0) begin
                                        wait_left--;
                                end
                                if (busy && wait_left == 0) begin
                                        busy = 1'b0;
                                        mem_ack <= 1'b1;
                                        mem_rdata <= mem[mem_addr[11:2]];
                                        if (mem_we) begin
                                                off = mem_addr[1:0];
                                                nb = (mem_size == ctrl_pkg::MEM_BYTE) ? 1
                                                   : (mem_size == ctrl_pkg::MEM_HALF_WORD) ? 2 : 4;
                                                lane = mem_wdata << (8 * off);
                                                for (int b = off; b < off + nb && b < 4; b++)
                                                        mem[mem_addr[11:2]][8*b +: 8] = lane[8*b +: 8];
                                                check_store(mem_addr, int'(mem_size), mem_wdata);
                                        end
                                end
                        end else if (!mem_req && mem_ack) begin
                                mem_ack <= 1'b0;
                        end
                end
        end

        initial begin
                int cycles, errors, passes;
                errors = 0;
                passes = 0;
                cycles = 0;
                while (!loaded && cycles < 10) begin
                        #1 cycles++;
                end
                if (!loaded) begin
                        $display("trace file was not loaded");
                        errors++;
                end
                cycles = 0;
                while (store_count < n_expected && !halted && cycles < 20000) begin
                        @(negedge clk) cycles++;
                end
                if (store_count < n_expected && !halted) begin
                        $display("timeout while waiting for the expected stores");
                        errors++;
                end
                cycles = 0;
                while (!halted && cycles < 500) begin
                        @(negedge clk) cycles++;
                end
                if (!halted) begin
                        $display("halted did not rise after the last store");
                        errors++;
                end else begin
                        $display("ok halt");
                        passes++;
                end
                cycles = 0;
                while (halted && !mem_req && cycles < 20) begin
                        @(negedge clk) cycles++;
                end
                if (!halted || mem_req) begin
                        $display("core left the halted state or requested memory");
                        errors++;
                end else begin
                        $display("ok quiet_after_halt");
                        passes++;
                end
                if (store_count != n_expected) begin
                        $display("store count wrong: trace lists %0d, core made %0d",
                                 n_expected, store_count);
                        errors++;
                end else begin
                        $display("ok store_count");
                        passes++;
                end
                $display("tests: %0d passed, %0d failed",
                         passes + store_pass, errors + store_fail);
                if (errors + store_fail == 0) begin
                        $display("No errors");
                end else begin
                        $display("Errors found");
                end
                $finish;
        end

endmodule

// File: test/core_trace.txt
# P addr word = program word, D addr word = initial data word
# S addr size(1 byte, 2 half, 3 word) data name = expected store
P 000 ff900093
P 004 00c00113
P 008 002081b3
P 00c 20302023
P 010 402081b3
P 014 20302223
P 018 0020f1b3
P 01c 20302423
P 020 0f00c193
P 024 20302623
P 028 002111b3
P 02c 20302823
P 030 4020d193
P 034 20302a23
P 038 0020a1b3
P 03c 20302c23
P 040 fff13193
P 044 20302e23
P 048 18000183
P 04c 22302023
P 050 18004183
P 054 22302223
P 058 18201183
P 05c 22302423
P 060 18205183
P 064 22302623
P 068 18002183
P 06c 22302823
P 070 181002a3
P 074 18201323
P 078 18402183
P 07c 22302a23
P 080 00210463
P 084 00150513
P 088 00209463
P 08c 00150513
P 090 0020c463
P 094 00150513
P 098 00115463
P 09c 00150513
P 0a0 00116463
P 0a4 00150513
P 0a8 0020f463
P 0ac 00150513
P 0b0 22a02c23
P 0b4 008002ef
P 0b8 00150513
P 0bc 22502e23
P 0c0 0c800367
P 0c4 ffffffff
P 0c8 24602023
P 0cc abcde1b7
P 0d0 24302223
P 0d4 00001197
P 0d8 24302423
P 0dc ffffffff
D 180 80f17f85
D 184 11223344
S 200 3 00000005 add
S 204 3 ffffffed sub
S 208 3 00000008 and
S 20c 3 ffffff09 xori
S 210 3 0000c000 sll
S 214 3 fffffffe srai
S 218 3 00000001 slt
S 21c 3 00000001 sltiu
S 220 3 ffffff85 lb
S 224 3 00000085 lbu
S 228 3 ffff80f1 lh
S 22c 3 000080f1 lhu
S 230 3 80f17f85 lw
S 185 1 000000f9 sb
S 186 2 0000000c sh
S 234 3 000cf944 sb_sh_readback
S 238 3 00000000 branches
S 23c 3 000000b8 jal_link
S 240 3 000000c4 jalr_link
S 244 3 abcde000 lui
S 248 3 000010d4 auipc

// File: flist.f
+incdir+hw
hw/isa_pkg.sv
hw/ctrl_pkg.sv
hw/control.sv
hw/alu.sv
hw/reg_file.sv
hw/core.sv
test/clk_gen.sv
test/tb_core.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f flist.f --top-module tb_core -o tb_core_sim
./obj_dir/tb_core_sim | tee sim.log
if grep -q "Errors found" sim.log; then
    exit 1
fi
